// File: design/arch_defs_pkg.sv
package arch_defs_pkg;

    // Datapath and bus widths
    localparam int DATA_WIDTH     = 8;
    localparam int APB_DATA_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;
    typedef logic [4:0]                apb_addr_t;
    typedef logic [1:0]                microstep_t;
    typedef logic [3:0]                alu_op_t;

    // Instruction opcodes; 4'hF has no member and decodes as illegal
    typedef enum logic [3:0] {
        LDI_A  = 4'h0,
        LDI_B  = 4'h1,
        LDI_C  = 4'h2,
        MOV_AB = 4'h3,
        MOV_AC = 4'h4,
        ADD    = 4'h5,
        SUB    = 4'h6,
        AND_OP = 4'h7,
        OR_OP  = 4'h8,
        XOR_OP = 4'h9,
        INR    = 4'hA,
        DCR    = 4'hB,
        SEC    = 4'hC,
        CLC    = 4'hD,
        NOP    = 4'hE
    } opcode_t;

    // ALU operations, PASS is zero so an idle control word selects it
    localparam alu_op_t ALU_PASS = 4'h0;
    localparam alu_op_t ALU_ADD  = 4'h1;
    localparam alu_op_t ALU_SUB  = 4'h2;
    localparam alu_op_t ALU_AND  = 4'h3;
    localparam alu_op_t ALU_OR   = 4'h4;
    localparam alu_op_t ALU_XOR  = 4'h5;
    localparam alu_op_t ALU_INR  = 4'h6;
    localparam alu_op_t ALU_DCR  = 4'h7;

    // Status bit positions, all other bits stay zero
    localparam int    STATUS_CPU_ZERO  = 0;
    localparam int    STATUS_CPU_CARRY = 1;
    localparam int    STATUS_CPU_NEG   = 2;
    localparam data_t STATUS_MASK      = 8'h07;

    // APB word offsets
    localparam apb_addr_t ADDR_REG_A   = 5'h00;
    localparam apb_addr_t ADDR_REG_B   = 5'h04;
    localparam apb_addr_t ADDR_REG_C   = 5'h08;
    localparam apb_addr_t ADDR_STATUS  = 5'h0C;
    localparam apb_addr_t ADDR_INSTR   = 5'h10;
    localparam apb_addr_t ADDR_VERSION = 5'h14;
    localparam data_t     CORE_VERSION = 8'h01;

    // Internal bus source
    localparam logic BUS_SEL_B = 1'b0;
    localparam logic BUS_SEL_C = 1'b1;

    // Instruction word, lives in PWDATA[11:0]
    typedef struct packed {
        opcode_t opcode;
        data_t   imm;
    } instr_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // Per-microstep control
    typedef struct packed {
        alu_op_t alu_op;
        opcode_t opcode;
        logic    load_temp;
        logic    load_a;
        logic    load_b;
        logic    load_c;
        logic    load_status;
        logic    load_sets_zn;
        logic    set_carry;
        logic    clear_carry;
        logic    bus_sel;
    } ctrl_word_t;

    typedef struct packed {
        logic      en;
        apb_addr_t addr;
        data_t     data;
    } host_wr_t;

endpackage

// File: design/alu.sv
`timescale 1ns/1ps

module alu (
    input  arch_defs_pkg::alu_op_t alu_op,
    input  arch_defs_pkg::data_t   a,
    input  arch_defs_pkg::data_t   b,
    output arch_defs_pkg::data_t   result,
    output logic                   zero,
    output logic                   carry,
    output logic                   negative
);

    import arch_defs_pkg::*;

    localparam logic [DATA_WIDTH:0] ONE = 1;

    // One spare bit on top holds carry out or borrow
    logic [DATA_WIDTH:0] wide;

    always_comb begin
        wide  = {1'b0, a};
        carry = 1'b0;
        case (alu_op)
            ALU_ADD: begin
                wide  = {1'b0, a} + {1'b0, b};
                carry = wide[DATA_WIDTH];
            end
            ALU_SUB: begin
                wide  = {1'b0, a} - {1'b0, b};
                // No borrow means a >= b
                carry = ~wide[DATA_WIDTH];
            end
            ALU_AND: wide = {1'b0, a & b};
            ALU_OR:  wide = {1'b0, a | b};
            ALU_XOR: wide = {1'b0, a ^ b};
            // Increment and decrement wrap, carry is held by the status logic
            ALU_INR: wide = {1'b0, a} + ONE;
            ALU_DCR: wide = {1'b0, a} - ONE;
            default: wide = {1'b0, a};
        endcase
    end

    assign result   = wide[DATA_WIDTH-1:0];
    // Flags straight off the result
    assign zero     = (result == '0);
    assign negative = result[DATA_WIDTH-1];

endmodule

// File: design/status_logic_unit.sv
`timescale 1ns/1ps

module status_logic_unit (
    // Raw ALU flags
    input  logic                   alu_zero,
    input  logic                   alu_carry,
    input  logic                   alu_negative,
    // Load or transfer sets Z and N
    input  logic                   load_sets_zn,
    input  arch_defs_pkg::opcode_t opcode,
    // Immediate source and transfer source
    input  arch_defs_pkg::data_t   temp_1_out,
    input  arch_defs_pkg::data_t   internal_bus,
    input  arch_defs_pkg::alu_op_t alu_op,
    // Held flags come from here
    input  arch_defs_pkg::data_t   current_status,
    // SEC and CLC
    input  logic                   set_carry_flag,
    input  logic                   clear_carry_flag,
    output logic                   zero_flag,
    output logic                   negative_flag,
    output logic                   carry_flag
);

    import arch_defs_pkg::*;

    logic loaded_is_zero;
    logic loaded_is_neg;

    // Z and N of the value a load or transfer writes
    always_comb begin
        loaded_is_zero = 1'b0;
        loaded_is_neg  = 1'b0;
        if (load_sets_zn) begin
            case (opcode)
                LDI_A, LDI_B, LDI_C: begin
                    loaded_is_zero = (temp_1_out == '0);
                    loaded_is_neg  = temp_1_out[DATA_WIDTH-1];
                end
                MOV_AB, MOV_AC: begin
                    loaded_is_zero = (internal_bus == '0);
                    loaded_is_neg  = internal_bus[DATA_WIDTH-1];
                end
                default: begin
                    loaded_is_zero = 1'b0;
                    loaded_is_neg  = 1'b0;
                end
            endcase
        end
    end

    always_comb begin
        // Start from the held flags
        zero_flag     = current_status[STATUS_CPU_ZERO];
        negative_flag = current_status[STATUS_CPU_NEG];
        carry_flag    = current_status[STATUS_CPU_CARRY];

        if (load_sets_zn) begin
            // Loads and transfers keep carry
            zero_flag     = loaded_is_zero;
            negative_flag = loaded_is_neg;
        end else if (!set_carry_flag && !clear_carry_flag) begin
            case (alu_op)
                // INR and DCR keep carry
                ALU_INR, ALU_DCR: begin
                    zero_flag     = alu_zero;
                    negative_flag = alu_negative;
                end
                default: begin
                    zero_flag     = alu_zero;
                    negative_flag = alu_negative;
                    carry_flag    = alu_carry;
                end
            endcase
        end

        // Explicit carry control wins
        if (set_carry_flag) begin
            carry_flag = 1'b1;
        end else if (clear_carry_flag) begin
            carry_flag = 1'b0;
        end
    end

endmodule

// File: design/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                      clk,
    input  logic                      reset,
    input  arch_defs_pkg::ctrl_word_t ctrl,
    input  arch_defs_pkg::host_wr_t   host_wr,
    input  arch_defs_pkg::data_t      alu_result,
    input  arch_defs_pkg::data_t      imm,
    input  logic                      zero_flag,
    input  logic                      negative_flag,
    input  logic                      carry_flag,
    output arch_defs_pkg::data_t      a_q,
    output arch_defs_pkg::data_t      b_q,
    output arch_defs_pkg::data_t      c_q,
    output arch_defs_pkg::data_t      status_q,
    output arch_defs_pkg::data_t      temp_q,
    output arch_defs_pkg::data_t      internal_bus
);

    import arch_defs_pkg::*;

    data_t temp_data;
    data_t dest_data;
    data_t next_status;

    assign internal_bus = (ctrl.bus_sel == BUS_SEL_C) ? c_q : b_q;

    // Temp source and destination mux
    always_comb begin
        case (ctrl.opcode)
            LDI_A, LDI_B, LDI_C: begin
                temp_data = imm;
                dest_data = imm;
            end
            MOV_AB, MOV_AC: begin
                temp_data = internal_bus;
                dest_data = internal_bus;
            end
            default: begin
                // ALU ops stage B as the second operand
                temp_data = internal_bus;
                dest_data = alu_result;
            end
        endcase
    end

    // Pack flags at their bit positions
    always_comb begin
        next_status                   = '0;
        next_status[STATUS_CPU_ZERO]  = zero_flag;
        next_status[STATUS_CPU_CARRY] = carry_flag;
        next_status[STATUS_CPU_NEG]   = negative_flag;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            a_q      <= '0;
            b_q      <= '0;
            c_q      <= '0;
            status_q <= '0;
            temp_q   <= '0;
        end else if (host_wr.en) begin
            // Host port, never active while an instruction runs
            case (host_wr.addr)
                ADDR_REG_A:  a_q <= host_wr.data;
                ADDR_REG_B:  b_q <= host_wr.data;
                ADDR_REG_C:  c_q <= host_wr.data;
                ADDR_STATUS: status_q <= host_wr.data & STATUS_MASK;
                default: ;
            endcase
        end else begin
            if (ctrl.load_temp) temp_q <= temp_data;
            if (ctrl.load_a) a_q <= dest_data;
            if (ctrl.load_b) b_q <= dest_data;
            if (ctrl.load_c) c_q <= dest_data;
            if (ctrl.load_status) status_q <= next_status;
        end
    end

endmodule

// File: design/microstep_counter.sv
`timescale 1ns/1ps

module microstep_counter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      clear,
    input  logic                      advance,
    input  arch_defs_pkg::microstep_t last_index,
    output arch_defs_pkg::microstep_t step,
    output logic                      last_step
);

    // Clear has priority, the controller holds it between instructions
    always_ff @(posedge clk) begin
        if (reset) begin
            step <= '0;
        end else if (clear) begin
            step <= '0;
        end else if (advance) begin
            step <= step + 1'b1;
        end
    end

    // Final step of the running instruction
    assign last_step = (step == last_index);

endmodule

// File: design/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  arch_defs_pkg::apb_req_t   apb_req,
    input  arch_defs_pkg::microstep_t step,
    input  logic                      last_step,
    input  arch_defs_pkg::data_t      a_q,
    input  arch_defs_pkg::data_t      b_q,
    input  arch_defs_pkg::data_t      c_q,
    input  arch_defs_pkg::data_t      status_q,
    output arch_defs_pkg::apb_data_t  prdata,
    output logic                      pready,
    output logic                      pslverr,
    output arch_defs_pkg::ctrl_word_t ctrl,
    output arch_defs_pkg::host_wr_t   host_wr,
    output logic                      step_clear,
    output logic                      step_advance,
    output arch_defs_pkg::microstep_t last_index
);

    import arch_defs_pkg::*;

    typedef enum logic [1:0] {IDLE, ACCESS, EXEC, DONE} state_t;

    state_t  state;
    state_t  state_next;
    instr_t  instr;
    opcode_t opcode_q;
    opcode_t cur_op;
    data_t   rd_byte;
    logic    access;
    logic    reg_addr;
    logic    op_legal;
    logic    instr_ok;
    logic    exec_active;
    logic    rd_ok;

    assign instr    = instr_t'(apb_req.pwdata[$bits(instr_t)-1:0]);
    // First access cycle of a transfer
    assign access   = (state == ACCESS) && apb_req.psel && apb_req.penable;
    assign reg_addr = apb_req.paddr inside {ADDR_REG_A, ADDR_REG_B, ADDR_REG_C, ADDR_STATUS};

    always_comb begin
        case (instr.opcode)
            LDI_A, LDI_B, LDI_C, MOV_AB, MOV_AC: op_legal = 1'b1;
            ADD, SUB, AND_OP, OR_OP, XOR_OP, INR, DCR: op_legal = 1'b1;
            SEC, CLC, NOP: op_legal = 1'b1;
            default: op_legal = 1'b0;
        endcase
    end

    assign instr_ok    = access && apb_req.pwrite && (apb_req.paddr == ADDR_INSTR) && op_legal;
    assign rd_ok       = !apb_req.pwrite && (reg_addr || apb_req.paddr == ADDR_VERSION);
    assign exec_active = instr_ok || (state == EXEC);
    // Step 0 decodes straight off PWDATA, later steps use the latched copy
    assign cur_op      = (state == EXEC) ? opcode_q : instr.opcode;

    // Wait states only while an instruction is short of its last step
    assign pready  = (access && !instr_ok) || (exec_active && last_step);
    assign pslverr = access && !(instr_ok || rd_ok || (apb_req.pwrite && reg_addr));

    // Step count per instruction class
    always_comb begin
        case (cur_op)
            LDI_A, LDI_B, LDI_C, MOV_AB, MOV_AC: last_index = 2'd1;
            ADD, SUB, AND_OP, OR_OP, XOR_OP, INR, DCR: last_index = 2'd2;
            default: last_index = 2'd0;
        endcase
    end

    assign step_advance = exec_active && !last_step;
    assign step_clear   = !step_advance;

    always_comb begin
        state_next = state;
        case (state)
            IDLE, DONE: state_next = (apb_req.psel && !apb_req.penable) ? ACCESS : IDLE;
            ACCESS:     state_next = (instr_ok && !last_step) ? EXEC : DONE;
            EXEC:       state_next = last_step ? DONE : EXEC;
            default:    state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            opcode_q <= NOP;
        end else begin
            state <= state_next;
            if (instr_ok) opcode_q <= instr.opcode;
        end
    end

    // Control word, zero outside execution
    always_comb begin
        ctrl = '0;
        if (exec_active) begin
            ctrl.opcode = cur_op;
            case (cur_op)
                LDI_A, LDI_B, LDI_C: begin
                    ctrl.load_temp    = (step == 2'd0);
                    ctrl.load_a       = (step == 2'd1) && (cur_op == LDI_A);
                    ctrl.load_b       = (step == 2'd1) && (cur_op == LDI_B);
                    ctrl.load_c       = (step == 2'd1) && (cur_op == LDI_C);
                    ctrl.load_status  = (step == 2'd1);
                    ctrl.load_sets_zn = (step == 2'd1);
                end
                MOV_AB, MOV_AC: begin
                    ctrl.bus_sel      = (cur_op == MOV_AC) ? BUS_SEL_C : BUS_SEL_B;
                    ctrl.load_a       = (step == 2'd1);
                    ctrl.load_status  = (step == 2'd1);
                    ctrl.load_sets_zn = (step == 2'd1);
                end
                ADD, SUB, AND_OP, OR_OP, XOR_OP, INR, DCR: begin
                    case (cur_op)
                        ADD:     ctrl.alu_op = ALU_ADD;
                        SUB:     ctrl.alu_op = ALU_SUB;
                        AND_OP:  ctrl.alu_op = ALU_AND;
                        OR_OP:   ctrl.alu_op = ALU_OR;
                        XOR_OP:  ctrl.alu_op = ALU_XOR;
                        INR:     ctrl.alu_op = ALU_INR;
                        default: ctrl.alu_op = ALU_DCR;
                    endcase
                    // Temp takes B, result lands in A on step 2
                    ctrl.bus_sel     = BUS_SEL_B;
                    ctrl.load_temp   = (step == 2'd0);
                    ctrl.load_a      = (step == 2'd2);
                    ctrl.load_status = (step == 2'd2);
                end
                SEC: begin
                    ctrl.load_status = 1'b1;
                    ctrl.set_carry   = 1'b1;
                end
                CLC: begin
                    ctrl.load_status = 1'b1;
                    ctrl.clear_carry = 1'b1;
                end
                default: ;
            endcase
        end
    end

    // Host register writes commit with PREADY
    assign host_wr.en   = access && apb_req.pwrite && reg_addr;
    assign host_wr.addr = apb_req.paddr;
    assign host_wr.data = apb_req.pwdata[DATA_WIDTH-1:0];

    always_comb begin
        case (apb_req.paddr)
            ADDR_REG_A:   rd_byte = a_q;
            ADDR_REG_B:   rd_byte = b_q;
            ADDR_REG_C:   rd_byte = c_q;
            ADDR_STATUS:  rd_byte = status_q;
            ADDR_VERSION: rd_byte = CORE_VERSION;
            default:      rd_byte = '0;
        endcase
    end

    assign prdata = (access && rd_ok) ? {{(APB_DATA_WIDTH-DATA_WIDTH){1'b0}}, rd_byte} : '0;

endmodule

// File: design/exec_core_top.sv
`timescale 1ns/1ps

module exec_core_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  arch_defs_pkg::apb_addr_t paddr,
    input  arch_defs_pkg::apb_data_t pwdata,
    output arch_defs_pkg::apb_data_t prdata,
    output logic                     pready,
    output logic                     pslverr
);

    import arch_defs_pkg::*;

    apb_req_t   apb_req;
    instr_t     instr;
    ctrl_word_t ctrl;
    host_wr_t   host_wr;
    microstep_t step;
    microstep_t last_index;
    logic       last_step;
    logic       step_clear;
    logic       step_advance;
    data_t      a_q;
    data_t      b_q;
    data_t      c_q;
    data_t      status_q;
    data_t      temp_q;
    data_t      internal_bus;
    data_t      alu_result;
    logic       alu_zero;
    logic       alu_carry;
    logic       alu_negative;
    logic       zero_flag;
    logic       negative_flag;
    logic       carry_flag;

    assign apb_req.psel    = psel;
    assign apb_req.penable = penable;
    assign apb_req.pwrite  = pwrite;
    assign apb_req.paddr   = paddr;
    assign apb_req.pwdata  = pwdata;
    // Immediate stays on PWDATA for the whole transfer
    assign instr = instr_t'(pwdata[$bits(instr_t)-1:0]);

    control_unit u_control_unit (
        .clk(clk), .reset(reset), .apb_req(apb_req), .step(step), .last_step(last_step),
        .a_q(a_q), .b_q(b_q), .c_q(c_q), .status_q(status_q),
        .prdata(prdata), .pready(pready), .pslverr(pslverr), .ctrl(ctrl),
        .host_wr(host_wr), .step_clear(step_clear), .step_advance(step_advance),
        .last_index(last_index)
    );

    microstep_counter u_microstep_counter (
        .clk(clk), .reset(reset), .clear(step_clear), .advance(step_advance),
        .last_index(last_index), .step(step), .last_step(last_step)
    );

    register_file u_register_file (
        .clk(clk), .reset(reset), .ctrl(ctrl), .host_wr(host_wr),
        .alu_result(alu_result), .imm(instr.imm),
        .zero_flag(zero_flag), .negative_flag(negative_flag), .carry_flag(carry_flag),
        .a_q(a_q), .b_q(b_q), .c_q(c_q), .status_q(status_q), .temp_q(temp_q),
        .internal_bus(internal_bus)
    );

    // Operand B always comes through temp
    alu u_alu (
        .alu_op(ctrl.alu_op), .a(a_q), .b(temp_q), .result(alu_result),
        .zero(alu_zero), .carry(alu_carry), .negative(alu_negative)
    );

    status_logic_unit u_status_logic_unit (
        .alu_zero(alu_zero), .alu_carry(alu_carry), .alu_negative(alu_negative),
        .load_sets_zn(ctrl.load_sets_zn), .opcode(ctrl.opcode),
        .temp_1_out(temp_q), .internal_bus(internal_bus), .alu_op(ctrl.alu_op),
        .current_status(status_q), .set_carry_flag(ctrl.set_carry),
        .clear_carry_flag(ctrl.clear_carry),
        .zero_flag(zero_flag), .negative_flag(negative_flag), .carry_flag(carry_flag)
    );

endmodule

// File: tests/exec_core_chk.sv
`timescale 1ns/1ps

module exec_core_chk (
    input logic                     clk,
    input logic                     reset,
    input logic                     psel,
    input logic                     penable,
    input arch_defs_pkg::apb_addr_t paddr,
    input logic                     pready,
    input logic                     pslverr
);

    // Count of failed assertions
    int unsigned fail_count = 0;

    // Bus outputs quiet once reset has been seen on an edge
    assert property (@(posedge clk) reset |=> (!pready && !pslverr))
        else begin
            $error("PREADY or PSLVERR high during reset");
            fail_count++;
        end

    // Longest instruction is three steps
    assert property (@(posedge clk) disable iff (reset)
        (psel && !penable) |=> ##[0:2] pready)
        else begin
            $error("PREADY missing three cycles after the setup phase");
            fail_count++;
        end

    // Address held through wait states
    assert property (@(posedge clk) disable iff (reset)
        (psel && penable && !pready) |=> $stable(paddr))
        else begin
            $error("PADDR changed during a wait state");
            fail_count++;
        end

endmodule

bind exec_core_top exec_core_chk u_exec_core_chk (
    .clk(clk), .reset(reset), .psel(psel), .penable(penable),
    .paddr(paddr), .pready(pready), .pslverr(pslverr)
);

// File: tests/exec_core_tb.sv
`timescale 1ns/1ps

module exec_core_tb;

    import arch_defs_pkg::*;

    // One table row: start state, instruction, expected end state
    typedef struct packed {
        data_t      a;
        data_t      b;
        data_t      c;
        data_t      status;
        opcode_t    op;
        data_t      imm;
        data_t      exp_a;
        data_t      exp_b;
        data_t      exp_c;
        logic [2:0] exp_flags;
    } vector_t;

    localparam int N_VECTORS = 19;
    localparam int N_RANDOM  = 32;
    // A vector is at most 20 cycles, the margin covers reset and directed accesses
    localparam int CYCLE_LIMIT = (N_VECTORS + N_RANDOM) * 20 + 200;

    // Columns: a, b, c, status, op, imm, exp_a, exp_b, exp_c, exp flags {N, C, Z}
    localparam vector_t VECTORS [N_VECTORS] = '{
        '{8'h11, 8'h22, 8'h33, 8'h02, LDI_A,  8'h80, 8'h80, 8'h22, 8'h33, 3'b110},
        '{8'h11, 8'h22, 8'h33, 8'h00, LDI_B,  8'h00, 8'h11, 8'h00, 8'h33, 3'b001},
        '{8'h11, 8'h22, 8'h33, 8'h07, LDI_C,  8'h7F, 8'h11, 8'h22, 8'h7F, 3'b010},
        '{8'h11, 8'hC5, 8'h33, 8'h00, MOV_AB, 8'h00, 8'hC5, 8'hC5, 8'h33, 3'b100},
        '{8'h11, 8'h22, 8'h00, 8'h02, MOV_AC, 8'h00, 8'h00, 8'h22, 8'h00, 3'b011},
        '{8'h7F, 8'h01, 8'h33, 8'h00, ADD,    8'h00, 8'h80, 8'h01, 8'h33, 3'b100},
        '{8'hFF, 8'h01, 8'h33, 8'h00, ADD,    8'h00, 8'h00, 8'h01, 8'h33, 3'b011},
        '{8'h05, 8'h05, 8'h33, 8'h00, SUB,    8'h00, 8'h00, 8'h05, 8'h33, 3'b011},
        '{8'h03, 8'h05, 8'h33, 8'h02, SUB,    8'h00, 8'hFE, 8'h05, 8'h33, 3'b100},
        '{8'hF0, 8'h3C, 8'h33, 8'h02, AND_OP, 8'h00, 8'h30, 8'h3C, 8'h33, 3'b000},
        '{8'h80, 8'h01, 8'h33, 8'h02, OR_OP,  8'h00, 8'h81, 8'h01, 8'h33, 3'b100},
        '{8'hAA, 8'hAA, 8'h33, 8'h00, XOR_OP, 8'h00, 8'h00, 8'hAA, 8'h33, 3'b001},
        '{8'hFF, 8'h22, 8'h33, 8'h02, INR,    8'h00, 8'h00, 8'h22, 8'h33, 3'b011},
        '{8'h7F, 8'h22, 8'h33, 8'h00, INR,    8'h00, 8'h80, 8'h22, 8'h33, 3'b100},
        '{8'h00, 8'h22, 8'h33, 8'h02, DCR,    8'h00, 8'hFF, 8'h22, 8'h33, 3'b110},
        '{8'h01, 8'h22, 8'h33, 8'h00, DCR,    8'h00, 8'h00, 8'h22, 8'h33, 3'b001},
        '{8'h42, 8'h22, 8'h33, 8'h05, SEC,    8'h00, 8'h42, 8'h22, 8'h33, 3'b111},
        '{8'h42, 8'h22, 8'h33, 8'h07, CLC,    8'h00, 8'h42, 8'h22, 8'h33, 3'b101},
        '{8'h42, 8'h22, 8'h33, 8'h02, NOP,    8'h00, 8'h42, 8'h22, 8'h33, 3'b010}
    };

    localparam opcode_t ALU_SET [7] = '{ADD, SUB, AND_OP, OR_OP, XOR_OP, INR, DCR};

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] lfsr_state = 32'hf277;

    exec_core_top u_exec_core_top (
        .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout, the run went past %0d cycles", CYCLE_LIMIT);
        $display("*** FAILED ***");
        $fatal(1, "Timeout");
    end

    // Bound protocol checker
    initial begin
        wait (u_exec_core_top.u_exec_core_chk.fail_count != 0);
        $display("Bus protocol assertion failed");
        $display("*** FAILED ***");
        $fatal(1, "Assertion failure");
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Microsteps per instruction class
    function automatic int step_count(input opcode_t op);
        case (op)
            SEC, CLC, NOP: return 1;
            LDI_A, LDI_B, LDI_C, MOV_AB, MOV_AC: return 2;
            default: return 3;
        endcase
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%02h expected 0x%02h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "Data mismatch");
        end
    endtask

    task automatic check_flags(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%01h expected 0x%01h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "Flag mismatch");
        end
    endtask

    task automatic check_resp(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%01h expected 0x%01h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "Response mismatch");
        end
    endtask

    task automatic check_waits(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "Wait state mismatch");
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic apb_transfer(input logic write, input apb_addr_t addr,
                                input apb_data_t wdata, input logic exp_err,
                                input int exp_waits, output data_t rdata);
        int waits;
        waits   = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready) begin
            waits++;
            @(posedge clk);
        end
        rdata = prdata[DATA_WIDTH-1:0];
        check_resp($sformatf("PSLVERR at 0x%02h", addr), pslverr, exp_err);
        check_waits($sformatf("wait states at 0x%02h", addr), waits, exp_waits);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata, input logic exp_err,
                             input int exp_waits);
        data_t unused;
        apb_transfer(1'b1, addr, wdata, exp_err, exp_waits, unused);
    endtask

    // Reads never wait
    task automatic apb_read(input apb_addr_t addr, input logic exp_err, output data_t value);
        apb_transfer(1'b0, addr, '0, exp_err, 0, value);
    endtask

    // Expected result and flags straight from the instruction rules
    task automatic model_alu(input opcode_t op, input data_t a, input data_t b,
                             input logic carry_in, output data_t result,
                             output logic [2:0] flags);
        logic [DATA_WIDTH:0] sum;
        logic                carry;
        carry = carry_in;
        case (op)
            ADD: begin
                sum    = {1'b0, a} + {1'b0, b};
                result = sum[DATA_WIDTH-1:0];
                carry  = sum[DATA_WIDTH];
            end
            SUB: begin
                result = a - b;
                carry  = (a >= b);
            end
            AND_OP: {carry, result} = {1'b0, a & b};
            OR_OP:  {carry, result} = {1'b0, a | b};
            XOR_OP: {carry, result} = {1'b0, a ^ b};
            INR:    result = a + 8'd1;
            DCR:    result = a - 8'd1;
            default: result = a;
        endcase
        flags = {result[DATA_WIDTH-1], carry, result == '0};
    endtask

    task automatic load_regs(input data_t a, input data_t b, input data_t c, input data_t status);
        apb_write(ADDR_REG_A, apb_data_t'(a), 1'b0, 0);
        apb_write(ADDR_REG_B, apb_data_t'(b), 1'b0, 0);
        apb_write(ADDR_REG_C, apb_data_t'(c), 1'b0, 0);
        apb_write(ADDR_STATUS, apb_data_t'(status), 1'b0, 0);
    endtask

    task automatic expect_regs(input string tag, input data_t a, input data_t b,
                               input data_t c, input logic [2:0] flags);
        data_t value;
        apb_read(ADDR_REG_A, 1'b0, value);
        check_data({tag, " A"}, value, a);
        apb_read(ADDR_REG_B, 1'b0, value);
        check_data({tag, " B"}, value, b);
        apb_read(ADDR_REG_C, 1'b0, value);
        check_data({tag, " C"}, value, c);
        apb_read(ADDR_STATUS, 1'b0, value);
        check_flags({tag, " flags"}, {value[STATUS_CPU_NEG], value[STATUS_CPU_CARRY],
                                      value[STATUS_CPU_ZERO]}, flags);
        // Bits above the three flags read as zero
        check_data({tag, " status spare bits"}, value & 8'hF8, 8'h00);
    endtask

    task automatic apply_vector(input vector_t v, input string tag);
        instr_t word;
        word.opcode = v.op;
        word.imm    = v.imm;
        load_regs(v.a, v.b, v.c, v.status);
        // PREADY comes with the last microstep
        apb_write(ADDR_INSTR, apb_data_t'(word), 1'b0, step_count(v.op) - 1);
        expect_regs(tag, v.exp_a, v.exp_b, v.exp_c, v.exp_flags);
    endtask

    initial begin
        vector_t v;
        instr_t  word;
        data_t   value;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        // Host access and version, spare status bits dropped on write
        load_regs(8'h3C, 8'hC3, 8'h5A, 8'hF5);
        expect_regs("host", 8'h3C, 8'hC3, 8'h5A, 3'b101);
        apb_read(ADDR_VERSION, 1'b0, value);
        check_data("version", value, 8'h01);

        for (int i = 0; i < N_VECTORS; i++) begin
            apply_vector(VECTORS[i], $sformatf("vector %0d", i));
        end

        // LFSR operands and start flags
        for (int i = 0; i < N_RANDOM; i++) begin
            v.a      = data_t'(random_bits(8));
            v.b      = data_t'(random_bits(8));
            v.c      = 8'h33;
            v.status = data_t'(random_bits(3));
            v.op     = ALU_SET[random_bits(3) % 7];
            v.imm    = 8'h00;
            v.exp_b  = v.b;
            v.exp_c  = v.c;
            model_alu(v.op, v.a, v.b, v.status[STATUS_CPU_CARRY], v.exp_a, v.exp_flags);
            apply_vector(v, $sformatf("random %0d", i));
        end

        // Error responses leave the registers alone
        load_regs(8'h5A, 8'hA5, 8'h3C, 8'h05);
        word.opcode = opcode_t'(4'hF);
        word.imm    = 8'h99;
        apb_write(ADDR_INSTR, apb_data_t'(word), 1'b1, 0);
        apb_write(5'h18, 32'h0000_00FF, 1'b1, 0);
        apb_read(5'h1C, 1'b1, value);
        apb_read(ADDR_INSTR, 1'b1, value);
        expect_regs("errors", 8'h5A, 8'hA5, 8'h3C, 3'b101);

        repeat (3) @(negedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: verilog.f
design/arch_defs_pkg.sv
design/alu.sv
design/status_logic_unit.sv
design/register_file.sv
design/microstep_counter.sv
design/control_unit.sv
design/exec_core_top.sv
tests/exec_core_chk.sv
tests/exec_core_tb.sv
